// ==== sources.f ====
+incdir+.
flow_id_pkg.sv
id_allocator.sv
state_id_manager.sv
bank_dispatch.sv
delete_drain.sv
flow_id_subsys.sv
tb_flow_id_subsys.sv

// ==== Makefile ====
VERILATOR  := verilator
TB_TOP     := tb_flow_id_subsys
RTL_TOP    := flow_id_subsys
FILELIST   := sources.f
SIM_FLAGS  := --binary --assert --timing -j 0
LINT_FLAGS := --lint-only --timing
SIM_BIN    := obj_dir/V$(TB_TOP)
PASS_MSG   := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)

# Pass only when the pass message shows up in the simulation output
run: build
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// ==== tb_flow_id_subsys.sv ====
`timescale 1ns/1ps
`include "flow_id_defines.svh"

module tb_flow_id_subsys
    import flow_id_pkg::*;
();

    localparam int NB             = `FLOW_NUM_BANKS;
    localparam int NL             = 2**`FLOW_LOCAL_ID_WID;
    localparam int NUM_IDS        = NB * NL;
    localparam int INIT_CYCLES    = 18;
    // Roughly twice the length of the full test sequence
    localparam int TIMEOUT_CYCLES = 3000;

    logic      clk = 1'b0;
    logic      srst;
    logic      init_done;
    logic      insert_req;
    flow_key_t insert_key;
    logic      insert_rdy;
    flow_id_t  insert_id;
    logic      del_req;
    flow_id_t  del_id;
    logic      del_ack;
    logic      key_req;
    key_del_t  key_del;
    logic      key_ack;
    logic      key_error;
    del_done_t del_done;

    // Scoreboard state
    logic [NL-1:0] used_model [NB];
    flow_key_t     key_model [NUM_IDS];
    bit            refused_key [2**`FLOW_KEY_WID];
    int            rr_model = 0;
    logic [NB-1:0] pend_busy = '0;
    logic [NB-1:0] pend_err = '0;
    logic [NB-1:0] key_seen = '0;
    local_id_t     pend_local [NB];
    del_done_t     last_done = '0;
    flow_key_t     key_seq = 16'h1000;
    int            del_cnt = 0;
    int            done_cnt = 0;
    int            max_busy = 0;
    int            cycle_cnt = 0;
    int            seed = 77;

    flow_id_subsys i_flow_id_subsys (
        .clk        (clk),
        .srst       (srst),
        .init_done  (init_done),
        .insert_req (insert_req),
        .insert_key (insert_key),
        .insert_rdy (insert_rdy),
        .insert_id  (insert_id),
        .del_req    (del_req),
        .del_id     (del_id),
        .del_ack    (del_ack),
        .key_req    (key_req),
        .key_del    (key_del),
        .key_ack    (key_ack),
        .key_error  (key_error),
        .del_done   (del_done)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    // ------------------------------------------------------------
    // Failure reporting
    // ------------------------------------------------------------
    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic report_error(input string msg);
        $display("[FAIL] %0d ns: %s", $time, msg);
        abort_run();
    endtask

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    // First bank with room at or after the pointer, then its lowest free ID
    function automatic flow_id_t predict_insert();
        flow_id_t id;
        int       b;
        logic     got_bank;
        logic     got_id;
        id       = '0;
        got_bank = 1'b0;
        for (int k = 0; k < NB; k++) begin
            b = (rr_model + k) % NB;
            if (!got_bank && used_model[b] != '1) begin
                got_bank = 1'b1;
                got_id   = 1'b0;
                id.bank  = bank_t'(b);
                for (int i = 0; i < NL; i++) begin
                    if (!got_id && !used_model[b][i]) begin
                        got_id      = 1'b1;
                        id.local_id = local_id_t'(i);
                    end
                end
            end
        end
        return id;
    endfunction

    function automatic logic model_full();
        logic full;
        full = 1'b1;
        for (int b = 0; b < NB; b++) begin
            if (used_model[b] != '1) begin
                full = 1'b0;
            end
        end
        return full;
    endfunction

    function automatic flow_id_t make_id(input int b, input int l);
        flow_id_t id;
        id.bank     = bank_t'(b);
        id.local_id = local_id_t'(l);
        return id;
    endfunction

    function automatic flow_key_t next_key();
        key_seq = key_seq + flow_key_t'(1);
        return key_seq;
    endfunction

    // ------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------
    task automatic insert_flow(input flow_key_t key, output flow_id_t id);
        flow_id_t exp;
        exp = predict_insert();
        @(negedge clk);
        insert_req = 1'b1;
        insert_key = key;
        @(posedge clk);
        assert (insert_rdy) else report_error("insert_rdy low while a free ID remains");
        assert (insert_id == exp)
            else report_error($sformatf("insert_id %0d.%0d, expected %0d.%0d",
                insert_id.bank, insert_id.local_id, exp.bank, exp.local_id));
        id = insert_id;
        used_model[exp.bank][exp.local_id] = 1'b1;
        key_model[{exp.bank, exp.local_id}] = key;
        rr_model = (int'(exp.bank) + 1) % NB;
        @(negedge clk);
        insert_req = 1'b0;
    endtask

    // Four-phase request that returns once del_ack is low again
    task automatic delete_id(input flow_id_t id);
        bank_t b;
        b = id.bank;
        @(negedge clk);
        del_req = 1'b1;
        del_id  = id;
        do @(posedge clk); while (!del_ack);
        pend_busy[b]  = 1'b1;
        pend_local[b] = id.local_id;
        pend_err[b]   = !used_model[b][id.local_id] ||
                        refused_key[key_model[{id.bank, id.local_id}]];
        key_seen[b]   = 1'b0;
        del_cnt       = del_cnt + 1;
        @(negedge clk);
        del_req = 1'b0;
        do @(posedge clk); while (del_ack);
    endtask

    task automatic wait_deletes();
        while (pend_busy != '0) begin
            @(posedge clk);
        end
    endtask

    // ------------------------------------------------------------
    // Flow table model
    // ------------------------------------------------------------
    initial begin : flow_table
        int       delay;
        key_del_t req;
        bank_t    b;
        forever begin
            @(posedge clk);
            if (key_req && !key_ack) begin
                req = key_del;
                b   = req.bank;
                assert (pend_busy[b]) else report_error("key_req from a bank with no delete");
                assert (!key_seen[b]) else report_error("second key_req for one delete");
                assert (req.key == key_model[{b, pend_local[b]}])
                    else report_error($sformatf("key_del key %h, expected %h",
                        req.key, key_model[{b, pend_local[b]}]));
                key_seen[b] = 1'b1;
                delay = $unsigned($random(seed)) % 8;
                @(negedge clk);
                repeat (delay) @(negedge clk);
                key_ack   = 1'b1;
                key_error = refused_key[req.key];
                do @(posedge clk); while (key_req);
                @(negedge clk);
                key_ack   = 1'b0;
                key_error = 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // Protocol and completion checks
    // ------------------------------------------------------------
    task automatic check_report();
        bank_t b;
        b = del_done.id.bank;
        assert (pend_busy[b]) else report_error("del_done with no open delete");
        assert (del_done.id.local_id == pend_local[b])
            else report_error($sformatf("del_done local ID %0d, expected %0d",
                del_done.id.local_id, pend_local[b]));
        assert (del_done.error == pend_err[b])
            else report_error($sformatf("del_done error %0b, expected %0b",
                del_done.error, pend_err[b]));
        // The table is asked only for IDs in use
        assert (key_seen[b] == used_model[b][pend_local[b]])
            else report_error($sformatf("key_req seen %0b for bank %0d", key_seen[b], b));
        if (!del_done.error) begin
            used_model[b][pend_local[b]] = 1'b0;
        end
        pend_busy[b] = 1'b0;
        done_cnt     = done_cnt + 1;
        last_done    = del_done;
    endtask

    initial begin : protocol_monitor
        logic     prev_key_req;
        logic     prev_key_ack;
        key_del_t prev_key_del;
        logic     prev_del_ack;
        prev_key_req = 1'b0;
        prev_key_ack = 1'b0;
        prev_key_del = '0;
        prev_del_ack = 1'b0;
        forever begin
            @(posedge clk);
            if (!srst) begin
                if (!init_done) begin
                    assert (!insert_rdy) else report_error("insert_rdy high before init_done");
                end
                if (prev_key_req && !prev_key_ack) begin
                    assert (key_req) else report_error("key_req dropped before key_ack");
                end
                if (key_req && prev_key_req) begin
                    assert (key_del == prev_key_del) else report_error("key_del changed");
                end
                if (key_req && !prev_key_req) begin
                    assert (!key_ack) else report_error("key_req rose while key_ack high");
                end
                if (del_ack && !prev_del_ack) begin
                    assert (del_req) else report_error("del_ack rose without del_req");
                end
                if (prev_del_ack && !del_ack) begin
                    assert (!del_req) else report_error("del_ack fell while del_req high");
                end
                if (del_done.valid) begin
                    check_report();
                end
                if ($countones(pend_busy) > max_busy) begin
                    max_busy = $countones(pend_busy);
                end
            end
            prev_key_req = key_req;
            prev_key_ack = key_ack;
            prev_key_del = key_del;
            prev_del_ack = del_ack;
        end
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin : stimulus
        flow_id_t           id;
        flow_id_t           target;
        int                 n;
        int                 idx;
        logic [NUM_IDS-1:0] picked;
        srst       = 1'b1;
        insert_req = 1'b0;
        insert_key = '0;
        del_req    = 1'b0;
        del_id     = '0;
        key_ack    = 1'b0;
        key_error  = 1'b0;
        for (int b = 0; b < NB; b++) begin
            used_model[b] = '0;
        end
        repeat (2) @(posedge clk);
        assert (!insert_rdy && !del_ack && !key_req && !del_done.valid)
            else report_error("outputs not low during reset");
        @(negedge clk);
        srst = 1'b0;

        // Init sweep sets init_done on the 18th edge
        n = 0;
        do begin
            @(posedge clk);
            n = n + 1;
        end while (!init_done);
        assert (n == INIT_CYCLES + 1)
            else report_error($sformatf("init_done after %0d cycles, expected %0d",
                n - 1, INIT_CYCLES));

        // Fill every bank
        for (int i = 0; i < NUM_IDS; i++) begin
            insert_flow(next_key(), id);
        end
        @(posedge clk);
        assert (!insert_rdy) else report_error("insert_rdy high with every bank full");

        // Plain delete and the freed ID comes back
        target = make_id(2, 5);
        delete_id(target);
        wait_deletes();
        insert_flow(next_key(), id);
        assert (id == target) else report_error("freed ID not returned by next insert");

        // Refused key keeps the ID in use
        target = make_id(1, 3);
        refused_key[key_model[{target.bank, target.local_id}]] = 1'b1;
        delete_id(target);
        wait_deletes();
        assert (last_done.error) else report_error("refused key reported without error");
        delete_id(make_id(1, 7));
        wait_deletes();
        insert_flow(next_key(), id);
        assert (id != target) else report_error("refused ID handed out again");
        @(posedge clk);
        assert (!insert_rdy) else report_error("insert_rdy high with every bank full");

        // Second delete of one ID hits an unallocated entry
        target = make_id(3, 9);
        delete_id(target);
        wait_deletes();
        delete_id(target);
        wait_deletes();
        assert (last_done.error) else report_error("unallocated ID reported without error");
        insert_flow(next_key(), id);

        // Spread deletes with random refusals
        picked = '0;
        for (int k = 0; k < 24; k++) begin
            do begin
                n   = $unsigned($random(seed)) % NL;
                idx = (k % NB) * NL + n;
            end while (picked[idx]);
            picked[idx] = 1'b1;
            if (($random(seed) & 3) == 0) begin
                refused_key[key_model[idx]] = 1'b1;
            end
            delete_id(make_id(k % NB, n));
        end
        wait_deletes();
        assert (max_busy >= 2) else report_error("no two banks were busy at once");
        assert (done_cnt == del_cnt)
            else report_error($sformatf("%0d reports for %0d deletes", done_cnt, del_cnt));
        while (!model_full()) begin
            insert_flow(next_key(), id);
        end
        @(posedge clk);
        assert (!insert_rdy) else report_error("insert_rdy high after refill");

        repeat (4) @(posedge clk);
        $display("Done: no errors");
        $finish;
    end

endmodule : tb_flow_id_subsys

// ==== flow_id_subsys.sv ====
`timescale 1ns/1ps
`include "flow_id_defines.svh"

module flow_id_subsys
    import flow_id_pkg::*;
(
    input  logic      clk,
    input  logic      srst,

    output logic      init_done,

    input  logic      insert_req,
    input  flow_key_t insert_key,
    output logic      insert_rdy,
    output flow_id_t  insert_id,

    input  logic      del_req,
    input  flow_id_t  del_id,
    output logic      del_ack,

    output logic      key_req,
    output key_del_t  key_del,
    input  logic      key_ack,
    input  logic      key_error,

    output del_done_t del_done
);

    logic [`FLOW_NUM_BANKS-1:0] bank_init_done;

    logic [`FLOW_NUM_BANKS-1:0] bank_insert_rdy;
    logic [`FLOW_NUM_BANKS-1:0] bank_insert_req;
    local_id_t                  bank_insert_id [`FLOW_NUM_BANKS];

    logic [`FLOW_NUM_BANKS-1:0] bank_del_req;
    logic [`FLOW_NUM_BANKS-1:0] bank_del_ack;
    local_id_t                  del_local_id;

    logic [`FLOW_NUM_BANKS-1:0] bank_key_req;
    logic [`FLOW_NUM_BANKS-1:0] bank_key_ack;
    logic [`FLOW_NUM_BANKS-1:0] bank_key_error;
    key_del_t                   bank_key_del [`FLOW_NUM_BANKS];

    logic [`FLOW_NUM_BANKS-1:0] bank_done_take;
    del_done_t                  bank_done [`FLOW_NUM_BANKS];

    assign init_done = &bank_init_done;

    // ------------------------------------------------------------
    // Dispatcher
    // ------------------------------------------------------------
    bank_dispatch i_bank_dispatch (
        .clk             (clk),
        .srst            (srst),
        .insert_req      (insert_req),
        .insert_rdy      (insert_rdy),
        .insert_id       (insert_id),
        .bank_insert_rdy (bank_insert_rdy),
        .bank_insert_id  (bank_insert_id),
        .bank_insert_req (bank_insert_req),
        .del_req         (del_req),
        .del_id          (del_id),
        .del_ack         (del_ack),
        .bank_del_req    (bank_del_req),
        .bank_del_ack    (bank_del_ack),
        .del_local_id    (del_local_id)
    );

    // ------------------------------------------------------------
    // Banks
    // ------------------------------------------------------------
    for (genvar b = 0; b < `FLOW_NUM_BANKS; b++) begin : g_bank
        state_id_manager i_state_id_manager (
            .clk          (clk),
            .srst         (srst),
            .bank_idx     (bank_t'(b)),
            .init_done    (bank_init_done[b]),
            .insert_rdy   (bank_insert_rdy[b]),
            .insert_req   (bank_insert_req[b]),
            .insert_key   (insert_key),
            .insert_id    (bank_insert_id[b]),
            .del_req      (bank_del_req[b]),
            .del_local_id (del_local_id),
            .del_ack      (bank_del_ack[b]),
            .key_req      (bank_key_req[b]),
            .key_del      (bank_key_del[b]),
            .key_ack      (bank_key_ack[b]),
            .key_error    (bank_key_error[b]),
            .done         (bank_done[b]),
            .done_take    (bank_done_take[b])
        );
    end

    // ------------------------------------------------------------
    // Drain to the flow table
    // ------------------------------------------------------------
    delete_drain i_delete_drain (
        .clk            (clk),
        .srst           (srst),
        .bank_key_req   (bank_key_req),
        .bank_key_del   (bank_key_del),
        .bank_key_ack   (bank_key_ack),
        .bank_key_error (bank_key_error),
        .key_req        (key_req),
        .key_del        (key_del),
        .key_ack        (key_ack),
        .key_error      (key_error),
        .bank_done      (bank_done),
        .bank_done_take (bank_done_take),
        .del_done       (del_done)
    );

endmodule : flow_id_subsys

// ==== delete_drain.sv ====
`timescale 1ns/1ps
`include "flow_id_defines.svh"

module delete_drain
    import flow_id_pkg::*;
(
    input  logic                       clk,
    input  logic                       srst,

    // Key deletes from the banks
    input  logic [`FLOW_NUM_BANKS-1:0] bank_key_req,
    input  key_del_t                   bank_key_del [`FLOW_NUM_BANKS],
    output logic [`FLOW_NUM_BANKS-1:0] bank_key_ack,
    output logic [`FLOW_NUM_BANKS-1:0] bank_key_error,

    // External flow table port
    output logic                       key_req,
    output key_del_t                   key_del,
    input  logic                       key_ack,
    input  logic                       key_error,

    // Completion reports
    input  del_done_t                  bank_done [`FLOW_NUM_BANKS],
    output logic [`FLOW_NUM_BANKS-1:0] bank_done_take,
    output del_done_t                  del_done
);

    bank_t rr_ptr;
    bank_t grant;
    logic  locked;

    logic [`FLOW_NUM_BANKS-1:0] done_valid;
    bank_t                      done_sel;

    // ------------------------------------------------------------
    // Key request arbitration
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            locked <= 1'b0;
            grant  <= '0;
            rr_ptr <= '0;
        end else if (!locked && |bank_key_req) begin
            locked <= 1'b1;
            grant  <= rr_pick(bank_key_req, rr_ptr);
        end else if (locked && !bank_key_req[grant] && !key_ack) begin
            // Both sides back to zero
            locked <= 1'b0;
            rr_ptr <= grant + bank_t'(1);
        end
    end

    assign key_req = locked && bank_key_req[grant];
    assign key_del = bank_key_del[grant];

    always_comb begin
        bank_key_ack   = '0;
        bank_key_error = '0;
        bank_key_ack[grant]   = locked && key_ack;
        bank_key_error[grant] = locked && key_error;
    end

    // ------------------------------------------------------------
    // Completion merge with the lowest bank first
    // ------------------------------------------------------------
    always_comb begin
        done_sel = '0;
        for (int i = `FLOW_NUM_BANKS - 1; i >= 0; i--) begin
            done_valid[i] = bank_done[i].valid;
            if (bank_done[i].valid) begin
                done_sel = bank_t'(i);
            end
        end
        bank_done_take = '0;
        bank_done_take[done_sel] = |done_valid;
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            del_done <= '0;
        end else begin
            del_done <= bank_done[done_sel];
        end
    end

endmodule : delete_drain

// ==== bank_dispatch.sv ====
`timescale 1ns/1ps
`include "flow_id_defines.svh"

module bank_dispatch
    import flow_id_pkg::*;
(
    input  logic                       clk,
    input  logic                       srst,

    // Insert from outside
    input  logic                       insert_req,
    output logic                       insert_rdy,
    output flow_id_t                   insert_id,

    // Insert to the banks
    input  logic [`FLOW_NUM_BANKS-1:0] bank_insert_rdy,
    input  local_id_t                  bank_insert_id [`FLOW_NUM_BANKS],
    output logic [`FLOW_NUM_BANKS-1:0] bank_insert_req,

    // Delete by ID from outside
    input  logic                       del_req,
    input  flow_id_t                   del_id,
    output logic                       del_ack,

    // Delete by ID to the banks
    output logic [`FLOW_NUM_BANKS-1:0] bank_del_req,
    input  logic [`FLOW_NUM_BANKS-1:0] bank_del_ack,
    output local_id_t                  del_local_id
);

    bank_t rr_ptr;
    bank_t ins_sel;

    bank_t del_bank;
    logic  del_open;

    // ------------------------------------------------------------
    // Insert by round robin over ready banks
    // ------------------------------------------------------------
    assign ins_sel    = rr_pick(bank_insert_rdy, rr_ptr);
    assign insert_rdy = |bank_insert_rdy;
    assign insert_id  = '{bank: ins_sel, local_id: bank_insert_id[ins_sel]};

    always_comb begin
        bank_insert_req = '0;
        bank_insert_req[ins_sel] = insert_req && insert_rdy;
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            rr_ptr <= '0;
        end else if (insert_req && insert_rdy) begin
            rr_ptr <= ins_sel + bank_t'(1);
        end
    end

    // ------------------------------------------------------------
    // Delete by ID relay
    // ------------------------------------------------------------
    // Ack follows the latched bank through both edges
    assign del_ack = bank_del_ack[del_bank];

    always_ff @(posedge clk) begin
        if (srst) begin
            del_open <= 1'b0;
            del_bank <= '0;
        end else if (!del_open && del_req && !del_ack) begin
            del_open <= 1'b1;
            del_bank <= del_id.bank;
        end else if (del_open && !del_req && del_ack) begin
            del_open <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!del_open && del_req) begin
            del_local_id <= del_id.local_id;
        end
    end

    always_comb begin
        bank_del_req = '0;
        bank_del_req[del_bank] = del_open;
    end

endmodule : bank_dispatch

// ==== state_id_manager.sv ====
`timescale 1ns/1ps

module state_id_manager
    import flow_id_pkg::*;
(
    input  logic      clk,
    input  logic      srst,

    input  bank_t     bank_idx,

    output logic      init_done,

    // Insert from the dispatcher
    output logic      insert_rdy,
    input  logic      insert_req,
    input  flow_key_t insert_key,
    output local_id_t insert_id,

    // Four-phase delete by ID
    input  logic      del_req,
    input  local_id_t del_local_id,
    output logic      del_ack,

    // Four-phase delete by key
    output logic      key_req,
    output key_del_t  key_del,
    input  logic      key_ack,
    input  logic      key_error,

    // Completion report
    output del_done_t done,
    input  logic      done_take
);

    localparam int NUM_IDS = 2**$bits(local_id_t);

    delete_state_t state;
    delete_state_t nxt_state;

    local_id_t init_cnt;

    logic      alloc_rdy;
    local_id_t alloc_id;
    logic      ins_fire;
    logic      query_used;
    logic      del_accept;

    local_id_t del_id;
    logic      del_err;
    flow_key_t rd_key;

    flow_key_t revmap [NUM_IDS];

    // ------------------------------------------------------------
    // Allocator
    // ------------------------------------------------------------
    id_allocator i_id_allocator (
        .clk         (clk),
        .srst        (srst),
        .init        (state == INIT),
        .alloc_req   (ins_fire),
        .alloc_rdy   (alloc_rdy),
        .alloc_id    (alloc_id),
        .dealloc_req (state == DEALLOC),
        .dealloc_id  (del_id),
        .query_id    (del_id),
        .query_used  (query_used)
    );

    assign insert_rdy = init_done && alloc_rdy;
    assign insert_id  = alloc_id;
    assign ins_fire   = insert_req && insert_rdy;

    // ------------------------------------------------------------
    // Reverse map from ID to key
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (state == INIT) begin
            revmap[init_cnt] <= '0;
        end else if (ins_fire) begin
            revmap[alloc_id] <= insert_key;
        end
        // Registered read with one cycle of latency
        if (state == REVMAP_READ) begin
            rd_key <= revmap[del_id];
        end
    end

    // Init sweep counter and done flag
    always_ff @(posedge clk) begin
        if (srst) begin
            init_cnt  <= '0;
            init_done <= 1'b0;
        end else begin
            if (state == INIT) begin
                init_cnt <= init_cnt + local_id_t'(1);
            end
            if (state == IDLE) begin
                init_done <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Delete-by-ID handshake
    // ------------------------------------------------------------
    assign del_accept = (state == IDLE) && init_done && del_req && !del_ack;

    always_ff @(posedge clk) begin
        if (srst) begin
            del_ack <= 1'b0;
        end else if (!del_req) begin
            del_ack <= 1'b0;
        end else if (del_accept) begin
            del_ack <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (del_accept) begin
            del_id <= del_local_id;
        end
        // Error for an unallocated ID or a refused key
        if (state == REVMAP_READ) begin
            del_err <= !query_used;
        end else if ((state == KEY_REQ) && key_ack) begin
            del_err <= key_error;
        end
    end

    // ------------------------------------------------------------
    // Deletion FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state <= RESET;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state = state;
        case (state)
            RESET       : nxt_state = INIT;
            INIT        : nxt_state = (init_cnt == '1) ? IDLE : INIT;
            IDLE        : nxt_state = del_accept ? REVMAP_READ : IDLE;
            REVMAP_READ : nxt_state = query_used ? KEY_REQ : REPORT;
            KEY_REQ     : nxt_state = key_ack ? KEY_WAIT : KEY_REQ;
            KEY_WAIT : begin
                if (!key_ack) begin
                    nxt_state = del_err ? REPORT : DEALLOC;
                end
            end
            DEALLOC     : nxt_state = REPORT;
            REPORT      : nxt_state = done_take ? IDLE : REPORT;
            default     : nxt_state = RESET;
        endcase
    end

    assign key_req = (state == KEY_REQ);
    assign key_del = '{key: rd_key, bank: bank_idx};

    // Report held until the drain takes it
    assign done = '{id: '{bank: bank_idx, local_id: del_id},
                    error: del_err,
                    valid: (state == REPORT)};

endmodule : state_id_manager

// ==== id_allocator.sv ====
`timescale 1ns/1ps

module id_allocator
    import flow_id_pkg::*;
(
    input  logic      clk,
    input  logic      srst,

    input  logic      init,

    input  logic      alloc_req,
    output logic      alloc_rdy,
    output local_id_t alloc_id,

    input  logic      dealloc_req,
    input  local_id_t dealloc_id,

    input  local_id_t query_id,
    output logic      query_used
);

    localparam int NUM_IDS = 2**$bits(local_id_t);

    // One bit per local ID, set while the ID is handed out
    logic [NUM_IDS-1:0] used;

    // ------------------------------------------------------------
    // Lowest free ID
    // ------------------------------------------------------------
    always_comb begin
        alloc_rdy = 1'b0;
        alloc_id  = '0;
        // Walk down so the lowest clear bit is the last one kept
        for (int i = NUM_IDS - 1; i >= 0; i--) begin
            if (!used[i]) begin
                alloc_rdy = 1'b1;
                alloc_id  = local_id_t'(i);
            end
        end
    end

    // ------------------------------------------------------------
    // Used bit vector
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst || init) begin
            used <= '0;
        end else begin
            if (alloc_req && alloc_rdy) begin
                used[alloc_id] <= 1'b1;
            end
            // Never the same ID as an allocation, that one is free
            if (dealloc_req) begin
                used[dealloc_id] <= 1'b0;
            end
        end
    end

    assign query_used = used[query_id];

endmodule : id_allocator

// ==== flow_id_pkg.sv ====
`include "flow_id_defines.svh"

package flow_id_pkg;

    typedef logic [`FLOW_LOCAL_ID_WID-1:0] local_id_t;
    typedef logic [`FLOW_BANK_WID-1:0]     bank_t;
    typedef logic [`FLOW_KEY_WID-1:0]      flow_key_t;

    // Global ID, bank number above the local ID
    typedef struct packed {
        bank_t     bank;
        local_id_t local_id;
    } flow_id_t;

    // External delete-by-key payload
    typedef struct packed {
        flow_key_t key;
        bank_t     bank;
    } key_del_t;

    // Completion report for one delete
    typedef struct packed {
        flow_id_t id;
        logic     error;
        logic     valid;
    } del_done_t;

    typedef enum logic [3:0] {
        RESET,
        INIT,
        IDLE,
        REVMAP_READ,
        KEY_REQ,
        KEY_WAIT,
        DEALLOC,
        REPORT
    } delete_state_t;

    // First set request bit at or after the pointer, wrapping around
    function automatic bank_t rr_pick(input logic [`FLOW_NUM_BANKS-1:0] req, input bank_t ptr);
        bank_t idx;
        bank_t pick;
        pick = ptr;
        for (int k = `FLOW_NUM_BANKS - 1; k >= 0; k--) begin
            idx = bank_t'((int'(ptr) + k) % `FLOW_NUM_BANKS);
            if (req[idx]) begin
                pick = idx;
            end
        end
        return pick;
    endfunction

endpackage : flow_id_pkg

// ==== flow_id_defines.svh ====
`ifndef FLOW_ID_DEFINES_SVH
`define FLOW_ID_DEFINES_SVH

// ------------------------------------------------------------
// Subsystem sizing
// ------------------------------------------------------------

// Banks in the ID space, all identical
`define FLOW_NUM_BANKS 4

// Bank number width, log2 of the bank count
`define FLOW_BANK_WID 2

// Local ID width inside one bank, 16 entries
`define FLOW_LOCAL_ID_WID 4

// Flow key width
`define FLOW_KEY_WID 16

`endif
